/* logic/vic_pkg.sv */
`default_nettype none

package vic_pkg;

    // serial link timing
    localparam int unsigned CLKS_PER_BIT = 16;               // sys_clock cycles per bit
    localparam int unsigned BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_CNT_W-1:0] BIT_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_W-1:0] HALF_BIT = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // chip model code, 3 is reserved and runs as 0
    typedef logic [1:0] chip_t;
    localparam chip_t CHIP_NTSC = 2'd0;                      // 6567R8
    localparam chip_t CHIP_PAL  = 2'd1;                      // 6569
    localparam chip_t CHIP_OLD  = 2'd2;                      // 6567R56A

    typedef logic [8:0] line_t;                              // raster line number

    // raster geometry, one count per character cycle
    localparam int unsigned CYC_W = 7;
    localparam logic [CYC_W-1:0] CYCLES_NTSC = 7'd65;
    localparam line_t            LINES_NTSC  = 9'd263;
    localparam logic [CYC_W-1:0] CYCLES_PAL  = 7'd63;
    localparam line_t            LINES_PAL   = 9'd312;
    localparam logic [CYC_W-1:0] CYCLES_OLD  = 7'd64;
    localparam line_t            LINES_OLD   = 9'd262;

    localparam logic [CYC_W-1:0] HSYNC_CYCLES  = 7'd4;       // at start of every line
    localparam line_t            VSYNC_LINES   = 9'd3;       // at start of every frame
    localparam logic [CYC_W-1:0] HBLANK_CYCLES = 7'd10;
    localparam line_t            VBLANK_LINES  = 9'd16;      // top and bottom alike

    // register map
    localparam logic [2:0] REG_CHIP     = 3'd0;
    localparam logic [2:0] REG_IRQ_LO   = 3'd1;
    localparam logic [2:0] REG_IRQ_HI   = 3'd2;
    localparam logic [2:0] REG_IRQ_CTRL = 3'd3;

    // one received byte, either a command or write data
    typedef union packed {
        struct packed {
            logic       write;                               // 1 = write, data byte follows
            logic [3:0] rsvd;
            logic [2:0] idx;                                 // register index
        } cmd;
        logic [7:0] raw;
    } cmd_byte_u;

endpackage : vic_pkg

`default_nettype wire

/* logic/serial_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_rx (
    input  wire logic       sys_clock,
    input  wire logic       rst_n,
    input  wire logic       rx,
    output logic      [7:0] rx_byte,
    output logic            rx_valid
);

    logic                            rx_meta;         // first sync stage
    logic                            rx_s;            // synchronized line
    logic                            rx_prev;         // for falling edge detect
    logic                            active;          // inside a frame
    logic [3:0]                      bit_idx;         // 0 start, 1..8 data, 9 stop
    logic [vic_pkg::BAUD_CNT_W-1:0]  baud_cnt;
    logic [7:0]                      shift;

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                          // line idles high
            rx_s    <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            active   <= 1'b0;
            bit_idx  <= 4'd0;
            baud_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_s) begin           // start edge
                    active   <= 1'b1;
                    bit_idx  <= 4'd0;
                    baud_cnt <= '0;
                end
            end else if (bit_idx == 4'd0) begin
                // half a bit in, the start bit must still be low
                if (baud_cnt == vic_pkg::HALF_BIT) begin
                    baud_cnt <= '0;
                    if (!rx_s) bit_idx <= 4'd1;
                    else       active  <= 1'b0;       // glitch, back to idle
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end else if (baud_cnt == vic_pkg::BIT_LAST) begin
                baud_cnt <= '0;
                if (bit_idx == 4'd9) begin            // mid stop bit
                    active   <= 1'b0;
                    rx_valid <= rx_s;                 // low stop bit drops the frame
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // data shifts in lsb first
    always_ff @(posedge sys_clock) begin
        if (active && bit_idx != 4'd0 && bit_idx != 4'd9 && baud_cnt == vic_pkg::BIT_LAST)
            shift <= {rx_s, shift[7:1]};
        if (active && bit_idx == 4'd9 && baud_cnt == vic_pkg::BIT_LAST)
            rx_byte <= shift;
    end

endmodule : serial_rx

`default_nettype wire

/* logic/serial_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_tx (
    input  wire logic       sys_clock,
    input  wire logic       rst_n,
    input  wire logic       tx_start,
    input  wire logic [7:0] tx_byte,
    output logic            tx,
    output logic            tx_busy
);

    logic [9:0]                      frame;           // stop, data, start; bit 0 on the line
    logic [3:0]                      bit_idx;         // 0..9
    logic [vic_pkg::BAUD_CNT_W-1:0]  baud_cnt;

    assign tx = frame[0];                             // all ones while idle

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            frame    <= '1;
            bit_idx  <= 4'd0;
            baud_cnt <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin                       // start bit on the next cycle
                frame    <= {1'b1, tx_byte, 1'b0};
                bit_idx  <= 4'd0;
                baud_cnt <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (baud_cnt == vic_pkg::BIT_LAST) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};           // back-fill with idle level
            if (bit_idx == 4'd9) tx_busy <= 1'b0;     // stop bit done
            else                 bit_idx <= bit_idx + 4'd1;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule : serial_tx

`default_nettype wire

/* logic/host_cmd_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module host_cmd_decoder (
    input  wire logic       sys_clock,
    input  wire logic       rst_n,
    input  wire logic [7:0] rx_byte,
    input  wire logic       rx_valid,
    input  wire logic [7:0] reg_rdata,
    output logic      [2:0] reg_addr,
    output logic      [7:0] reg_wdata,
    output logic            reg_wr,
    output logic            reg_rd,
    output logic      [7:0] tx_byte,
    output logic            tx_start
);

    vic_pkg::cmd_byte_u rx_word;                      // same byte, two views
    logic               await_data;                   // write command seen, data next

    assign rx_word.raw = rx_byte;

    // register block answers in the reg_rd cycle, tx latches it then
    assign tx_byte = reg_rdata;

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            await_data <= 1'b0;
            reg_wr     <= 1'b0;
            reg_rd     <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            reg_wr   <= 1'b0;
            reg_rd   <= 1'b0;
            tx_start <= 1'b0;
            if (rx_valid) begin
                if (await_data) begin
                    reg_wr     <= 1'b1;               // data byte completes the pair
                    await_data <= 1'b0;
                end else if (rx_word.cmd.write) begin
                    await_data <= 1'b1;
                end else begin
                    reg_rd   <= 1'b1;
                    tx_start <= 1'b1;                 // host keeps reads spaced out
                end
            end
        end
    end

    // index and data hold until the next strobe
    always_ff @(posedge sys_clock) begin
        if (rx_valid && !await_data)
            reg_addr <= rx_word.cmd.idx;
        if (rx_valid && await_data)
            reg_wdata <= rx_word.raw;
    end

endmodule : host_cmd_decoder

`default_nettype wire

/* logic/vic_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_regs (
    input  wire logic           sys_clock,
    input  wire logic           rst_n,
    input  wire logic     [2:0] reg_addr,
    input  wire logic     [7:0] reg_wdata,
    input  wire logic           reg_wr,
    input  wire logic           reg_rd,
    output logic          [7:0] reg_rdata,
    output vic_pkg::chip_t      chip,
    output vic_pkg::line_t      irq_line,
    input  wire logic           raster_match,
    output logic                irq
);

    logic irq_en;                                     // ctrl bit 0
    logic pending;                                    // ctrl bit 7
    logic irq_en_d;
    logic pending_d;

    // next state of the interrupt bits, irq follows it without extra delay
    always_comb begin
        irq_en_d  = irq_en;
        pending_d = pending;
        if (reg_wr && reg_addr == vic_pkg::REG_IRQ_CTRL) begin
            irq_en_d = reg_wdata[0];
            if (reg_wdata[7]) pending_d = 1'b0;       // write one to clear
        end
        if (raster_match) pending_d = 1'b1;           // set beats clear
    end

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            chip     <= vic_pkg::CHIP_NTSC;
            irq_line <= '0;
            irq_en   <= 1'b0;
            pending  <= 1'b0;
            irq      <= 1'b0;
        end else begin
            irq_en  <= irq_en_d;
            pending <= pending_d;
            irq     <= pending_d & irq_en_d;
            if (reg_wr) begin
                case (reg_addr)
                    vic_pkg::REG_CHIP:   chip          <= reg_wdata[1:0];
                    vic_pkg::REG_IRQ_LO: irq_line[7:0] <= reg_wdata;
                    vic_pkg::REG_IRQ_HI: irq_line[8]   <= reg_wdata[0];
                    default: ;                        // ctrl handled above, rest ignored
                endcase
            end
        end
    end

    // reads have no side effect, reg_rd just qualifies the mux
    always_comb begin
        reg_rdata = 8'h00;
        if (reg_rd) begin
            case (reg_addr)
                vic_pkg::REG_CHIP:     reg_rdata = {6'd0, chip};
                vic_pkg::REG_IRQ_LO:   reg_rdata = irq_line[7:0];
                vic_pkg::REG_IRQ_HI:   reg_rdata = {7'd0, irq_line[8]};
                vic_pkg::REG_IRQ_CTRL: reg_rdata = {pending, 6'd0, irq_en};
                default:               reg_rdata = 8'h00;
            endcase
        end
    end

endmodule : vic_regs

`default_nettype wire

/* logic/raster_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_timing (
    input  wire logic           sys_clock,
    input  wire logic           rst_n,
    input  vic_pkg::chip_t      chip,
    input  vic_pkg::line_t      irq_line,
    output logic                hsync,
    output logic                vsync,
    output logic                active,
    output logic                raster_match
);

    vic_pkg::chip_t                  chip_q;          // model of the running frame
    logic [vic_pkg::CYC_W-1:0]       cycle;           // character cycle in line
    vic_pkg::line_t                  line;
    logic [vic_pkg::CYC_W-1:0]       cycles_per_line;
    vic_pkg::line_t                  lines_per_frame;

    // geometry by chip model, reserved code runs as NTSC
    always_comb begin
        case (chip_q)
            vic_pkg::CHIP_PAL: begin
                cycles_per_line = vic_pkg::CYCLES_PAL;
                lines_per_frame = vic_pkg::LINES_PAL;
            end
            vic_pkg::CHIP_OLD: begin
                cycles_per_line = vic_pkg::CYCLES_OLD;
                lines_per_frame = vic_pkg::LINES_OLD;
            end
            default: begin
                cycles_per_line = vic_pkg::CYCLES_NTSC;
                lines_per_frame = vic_pkg::LINES_NTSC;
            end
        endcase
    end

    always_ff @(posedge sys_clock) begin
        if (!rst_n) begin
            chip_q <= vic_pkg::CHIP_NTSC;
            cycle  <= '0;
            line   <= '0;
        end else if (cycle == cycles_per_line - 7'd1) begin
            cycle <= '0;
            if (line == lines_per_frame - 9'd1) begin
                line   <= '0;
                chip_q <= chip;                       // new model only at frame wrap
            end else begin
                line <= line + 9'd1;
            end
        end else begin
            cycle <= cycle + 7'd1;
        end
    end

    // plain decodes of the counters
    assign hsync = cycle < vic_pkg::HSYNC_CYCLES;
    assign vsync = line < vic_pkg::VSYNC_LINES;

    assign active = (cycle >= vic_pkg::HBLANK_CYCLES) &&
                    (line >= vic_pkg::VBLANK_LINES) &&
                    (line < lines_per_frame - vic_pkg::VBLANK_LINES);

    assign raster_match = (cycle == '0) && (line == irq_line);  // once per frame

endmodule : raster_timing

`default_nettype wire

/* logic/vic_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_top (
    input  wire logic sys_clock,
    input  wire logic rst_n,
    input  wire logic rx,
    output logic      tx,
    output logic      hsync,
    output logic      vsync,
    output logic      active,
    output logic      irq
);

    logic [7:0]      rx_byte;
    logic            rx_valid;
    logic [2:0]      reg_addr;
    logic [7:0]      reg_wdata;
    logic            reg_wr;
    logic            reg_rd;
    logic [7:0]      reg_rdata;
    logic [7:0]      tx_byte;
    logic            tx_start;
    logic            tx_busy;                         // watched by the checker
    vic_pkg::chip_t  chip;
    vic_pkg::line_t  irq_line;
    logic            raster_match;

    serial_rx serial_rx_inst (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    host_cmd_decoder host_cmd_decoder_inst (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .reg_rdata (reg_rdata),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start)
    );

    vic_regs vic_regs_inst (
        .sys_clock    (sys_clock),
        .rst_n        (rst_n),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_rdata    (reg_rdata),
        .chip         (chip),
        .irq_line     (irq_line),
        .raster_match (raster_match),
        .irq          (irq)
    );

    raster_timing raster_timing_inst (
        .sys_clock    (sys_clock),
        .rst_n        (rst_n),
        .chip         (chip),
        .irq_line     (irq_line),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .raster_match (raster_match)
    );

    serial_tx serial_tx_inst (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx        (tx),
        .tx_busy   (tx_busy)
    );

endmodule : vic_top

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic sys_clock,
    output logic rst_n
);

    initial begin
        sys_clock = 1'b0;
        forever #10 sys_clock = ~sys_clock;           // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge sys_clock);              // two edges in reset
        rst_n <= 1'b1;
    end

endmodule : tb_clock

`default_nettype wire

/* dv/vic_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_chk (
    input wire logic sys_clock,
    input wire logic rst_n,
    input wire logic tx,
    input wire logic tx_busy,
    input wire logic reg_wr,
    input wire logic reg_rd,
    input wire logic rx_valid,
    input wire logic irq,
    input wire logic irq_en
);

    int fail_count = 0;                               // summed into the testbench totals

    // line idles high between frames
    tx_idle_high: assert property (@(posedge sys_clock) disable iff (!rst_n) !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the transmitter is idle");
        end

    wr_rd_exclusive: assert property (@(posedge sys_clock) disable iff (!rst_n)
        !(reg_wr && reg_rd))
        else begin
            fail_count++;
            $error("register write and read strobes in the same cycle");
        end

    rx_valid_pulse: assert property (@(posedge sys_clock) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid held for more than one cycle");
        end

    // irq may only come up with the enable bit set
    irq_needs_enable: assert property (@(posedge sys_clock) disable iff (!rst_n)
        $rose(irq) |-> irq_en)
        else begin
            fail_count++;
            $error("irq rose while the interrupt enable is low");
        end

endmodule : vic_chk

bind vic_top vic_chk vic_chk_inst (
    .sys_clock (sys_clock),
    .rst_n     (rst_n),
    .tx        (tx),
    .tx_busy   (tx_busy),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .rx_valid  (rx_valid),
    .irq       (irq),
    .irq_en    (vic_regs_inst.irq_en)
);

`default_nettype wire

/* dv/vic_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vic_tb;

    localparam int BIT_CYCLES = vic_pkg::CLKS_PER_BIT;
    localparam int WAIT_LIMIT = 40000;                // over two frames of any model
    localparam int SEL_HSYNC  = 0;
    localparam int SEL_VSYNC  = 1;
    localparam int SEL_ACTIVE = 2;
    localparam int SEL_IRQ    = 3;
    localparam int NTSC_LINE  = int'(vic_pkg::CYCLES_NTSC);
    localparam int NTSC_FRAME = NTSC_LINE * int'(vic_pkg::LINES_NTSC);
    localparam int PAL_LINE   = int'(vic_pkg::CYCLES_PAL);
    localparam int PAL_FRAME  = PAL_LINE * int'(vic_pkg::LINES_PAL);

    logic sys_clock;
    logic rst_n;
    logic rx;
    logic tx;
    logic hsync;
    logic vsync;
    logic active;
    logic irq;

    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    tb_clock tb_clock_inst (
        .sys_clock (sys_clock),
        .rst_n     (rst_n)
    );

    vic_top vic_top_inst (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active),
        .irq       (irq)
    );

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_chip(input string what, input vic_pkg::chip_t got,
                              input vic_pkg::chip_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is chip %0d, expected chip %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic sample_output(input int sel);
        case (sel)
            SEL_HSYNC:  return hsync;
            SEL_VSYNC:  return vsync;
            SEL_ACTIVE: return active;
            default:    return irq;
        endcase
    endfunction

    // called on a falling edge, cycles counts falling edges up to the rise
    task automatic wait_rise(input int sel, output int cycles);
        logic prev;
        logic cur;
        logic found;
        prev   = sample_output(sel);
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge sys_clock);
            cycles++;
            cur   = sample_output(sel);
            found = !prev && cur;
            prev  = cur;
        end
        if (!found) begin
            timeouts++;
            $display("timeout at %0t: no rising edge on output %0d", $time, sel);
        end
    endtask

    task automatic measure_period(input int sel, output int period);
        int skipped;
        wait_rise(sel, skipped);                      // align to a first edge
        wait_rise(sel, period);
    endtask

    task automatic measure_high(input int sel, output int high);
        int skipped;
        wait_rise(sel, skipped);
        high = 0;
        while (sample_output(sel) && high < WAIT_LIMIT) begin
            @(negedge sys_clock);
            high++;
        end
        if (sample_output(sel)) begin
            timeouts++;
            $display("timeout at %0t: output %0d never fell", $time, sel);
        end
    endtask

    // start, data lsb first, stop, then one idle bit
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [10:0] frame;
        frame = {1'b1, stop_bit, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge sys_clock);
            rx <= frame[i];
            repeat (BIT_CYCLES - 1) @(posedge sys_clock);
        end
        @(negedge sys_clock);                         // back on a falling edge
    endtask

    task automatic recv_byte(output logic [7:0] data);
        int n;
        data = 'x;
        n    = 0;
        while (tx !== 1'b0 && n < 16 * BIT_CYCLES) begin
            @(negedge sys_clock);
            n++;
        end
        if (tx !== 1'b0) begin
            timeouts++;
            $display("timeout at %0t: no response start bit on tx", $time);
            return;
        end
        repeat (BIT_CYCLES / 2) @(negedge sys_clock); // mid start bit
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge sys_clock);
            data[i] = tx;
        end
        repeat (BIT_CYCLES) @(negedge sys_clock);
        check_bit("response stop bit", tx, 1'b1);
    endtask

    task automatic write_reg(input logic [2:0] idx, input logic [7:0] data);
        vic_pkg::cmd_byte_u cmd;
        cmd.raw       = 8'h00;
        cmd.cmd.write = 1'b1;
        cmd.cmd.idx   = idx;
        send_byte(cmd.raw, 1'b1);
        send_byte(data, 1'b1);                        // register updated before this returns
    endtask

    task automatic read_reg(input logic [2:0] idx, output logic [7:0] data);
        vic_pkg::cmd_byte_u cmd;
        cmd.raw     = 8'h00;
        cmd.cmd.idx = idx;
        fork
            send_byte(cmd.raw, 1'b1);
            recv_byte(data);                          // response overlaps our stop bit
        join
    endtask

    task automatic test_ntsc_timing();
        int n;
        measure_period(SEL_HSYNC, n);
        check_count("ntsc hsync period", n, NTSC_LINE);
        measure_period(SEL_VSYNC, n);
        check_count("ntsc vsync period", n, NTSC_FRAME);
        measure_high(SEL_ACTIVE, n);
        check_count("ntsc active width", n, NTSC_LINE - int'(vic_pkg::HBLANK_CYCLES));
    endtask

    task automatic test_reg_access();
        logic [7:0] data;
        logic [7:0] got;
        logic [7:0] exp;
        for (int i = 0; i < 8; i++) begin
            data = 8'($urandom);
            write_reg(3'(i), data);
            read_reg(3'(i), got);
            exp = 8'h00;                              // unmapped indices
            if (i == 0) exp = {6'd0, data[1:0]};
            if (i == 1) exp = data;
            if (i == 2) exp = {7'd0, data[0]};
            if (i == 0) check_chip("chip field", got[1:0], data[1:0]);
            if (i == 3) begin
                // pending can be set by a match at any moment, only enable is known
                check_byte("irq ctrl enable", got & 8'h01, data & 8'h01);
            end else begin
                check_byte($sformatf("register %0d", i), got, exp);
            end
        end
    endtask

    task automatic test_chip_change();
        int         n;
        logic [7:0] got;
        write_reg(vic_pkg::REG_CHIP, 8'h01);
        read_reg(vic_pkg::REG_CHIP, got);
        check_chip("chip after pal write", got[1:0], vic_pkg::CHIP_PAL);
        measure_period(SEL_VSYNC, n);                 // first edge is the wrap that latches it
        check_count("pal vsync period", n, PAL_FRAME);
        measure_period(SEL_HSYNC, n);
        check_count("pal hsync period", n, PAL_LINE);
        write_reg(vic_pkg::REG_CHIP, 8'h03);
        read_reg(vic_pkg::REG_CHIP, got);
        check_chip("chip after reserved write", got[1:0], 2'd3);
        measure_period(SEL_VSYNC, n);                 // reserved code runs as ntsc
        check_count("reserved vsync period", n, NTSC_FRAME);
        measure_period(SEL_HSYNC, n);
        check_count("reserved hsync period", n, NTSC_LINE);
    endtask

    task automatic test_raster_irq();
        int             n;
        vic_pkg::line_t target;
        logic [7:0]     got;
        // keep clear of the last lines so a clear finishes inside the frame
        target = 9'($urandom % (int'(vic_pkg::LINES_NTSC) - 16));
        write_reg(vic_pkg::REG_IRQ_LO, target[7:0]);
        write_reg(vic_pkg::REG_IRQ_HI, {7'd0, target[8]});
        write_reg(vic_pkg::REG_IRQ_CTRL, 8'h81);      // enable, clear pending
        wait_rise(SEL_IRQ, n);
        write_reg(vic_pkg::REG_IRQ_CTRL, 8'h81);
        check_bit("irq after clear", irq, 1'b0);
        wait_rise(SEL_VSYNC, n);
        wait_rise(SEL_IRQ, n);
        check_count("irq delay after vsync", n, int'(target) * NTSC_LINE + 1);
        read_reg(vic_pkg::REG_IRQ_CTRL, got);
        check_bit("pending bit", got[7], 1'b1);
        write_reg(vic_pkg::REG_IRQ_CTRL, 8'h81);
        check_bit("irq after second clear", irq, 1'b0);
    endtask

    task automatic test_irq_disabled();
        int         n;
        logic       seen_high;
        logic [7:0] got;
        write_reg(vic_pkg::REG_IRQ_CTRL, 8'h80);      // enable off, pending cleared
        wait_rise(SEL_VSYNC, n);
        seen_high = 1'b0;
        for (int i = 0; i < NTSC_FRAME; i++) begin    // one whole frame
            @(negedge sys_clock);
            if (irq) seen_high = 1'b1;
        end
        check_bit("irq while disabled", seen_high, 1'b0);
        read_reg(vic_pkg::REG_IRQ_CTRL, got);
        check_byte("irq ctrl while disabled", got, 8'h80);
    endtask

    task automatic test_bad_frame();
        logic [7:0]         data;
        logic [7:0]         got;
        vic_pkg::cmd_byte_u cmd;
        data = 8'($urandom);
        write_reg(vic_pkg::REG_IRQ_LO, data);
        cmd.raw       = 8'h00;
        cmd.cmd.write = 1'b1;
        cmd.cmd.idx   = vic_pkg::REG_IRQ_LO;
        send_byte(cmd.raw, 1'b0);                     // low stop bit
        // had the write command got through, this read would land as its data
        read_reg(vic_pkg::REG_IRQ_LO, got);
        check_byte("irq line after bad frame", got, data);
    endtask

    initial begin
        int n;
        int chk_fails;
        rx <= 1'b1;
        void'($urandom(32'hab3fed2b));
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge sys_clock);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t: reset never released", $time);
        end
        check_bit("tx after reset", tx, 1'b1);
        check_bit("irq after reset", irq, 1'b0);
        check_bit("hsync after reset", hsync, 1'b1);
        check_bit("vsync after reset", vsync, 1'b1);
        test_ntsc_timing();
        test_reg_access();
        test_chip_change();
        test_raster_irq();
        test_irq_disabled();
        test_bad_frame();
        chk_fails = vic_top_inst.vic_chk_inst.fail_count;
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, chk_fails);
        if (errors == 0 && timeouts == 0 && chk_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : vic_tb

`default_nettype wire

/* all.f */
logic/vic_pkg.sv
logic/serial_rx.sv
logic/serial_tx.sv
logic/host_cmd_decoder.sv
logic/vic_regs.sv
logic/raster_timing.sv
logic/vic_top.sv
dv/tb_clock.sv
dv/vic_chk.sv
dv/vic_tb.sv

/* Makefile */
TOP = vic_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f all.f --top-module $(TOP) -o $(TOP)

# keep running past assertion errors so the testbench prints its verdict
run: build
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
